/* bench/rram_stimulus.txt */
// 00 instructions {code,opcode}, 08 data packets, 10 ADC code per column 0..63
// 50 expected output words 0..15
@00
40045 40249 A1234 50003
@08
0A5C3 01E2D 0F00F 06B49
@10
3 a 1 8 f 6 d 4 b 2 9 0 7 e 5 c
8 f 6 d 4 b 2 9 0 7 e 5 c 3 a 1
d 4 b 2 9 0 7 e 5 c 3 a 1 8 f 6
2 9 0 7 e 5 c 3 a 1 8 f 6 d 4 b
@50
81a3 4d6f 092b c5e7 d6f8 92b4 5e70 1a3c
2b4d e709 a3c5 6f81 7092 3c5e f81a b4d6

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors = 0;   // Wrong values seen on DUT outputs
int other_errors = 0;   // Timeouts and protocol faults

task automatic check_word(input string name, input xbar_pkg::data_word_t got,
                          input xbar_pkg::data_word_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_line_sel(input string name, input xbar_pkg::line_sel_t got,
                              input xbar_pkg::line_sel_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_row_sel(input string name, input logic [xbar_pkg::num_wl-1:0] got,
                             input logic [xbar_pkg::num_wl-1:0] exp);
    if (got !== exp) begin
        value_errors++;
        $display("FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

// Bias bits packed as {wl, bl[2:0], sl}
task automatic check_bias(input string name, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
        value_errors++;
        $display("FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic count_failure(input string msg);
    other_errors++;
    $display("Error at %0t: %s", $time, msg);
endtask

task automatic report_counts();
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
endtask

`endif

/* bench/tb_rram_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rram_ctrl;

    `include "tb_checks.svh"

    localparam int wc = 4;                        // Pulses per polarity
    localparam int data_at = 8;                   // Stimulus file layout
    localparam int adc_at  = 16;
    localparam int exp_at  = 80;

    logic CLK = 1'b0, RESET_ACC = 1'b1;
    logic instr_empty, data_empty, out_full, pop_n_instr, pop_n_data, push_n_out;
    ctrl_pkg::instr_word_t instr_dout;
    xbar_pkg::data_word_t data_dout, out_din;
    xbar_pkg::therm_t adc_therm [xbar_pkg::num_adc];
    logic [63:0] wl_sel, sl_mux_sel;
    xbar_pkg::line_sel_t [63:0] bl_sel, sl_sel;
    logic wl_bias_sel, sl_bias_sel;
    logic [2:0] bl_bias_sel;

    logic [19:0] stim [0:127];
    logic [19:0] instr_q [$];
    logic [15:0] data_q [$];
    int pcount = 0, rcount = 0, ocount = 0, ipops = 0, dpops = 0;
    int pc_start, st_row, st_pkt, st_base, rd_row;
    bit rand_full = 0, aborted = 0;

    rram_ctrl_top #(.write_cycles(wc)) rram_ctrl_top_i (.*);

    initial begin
        forever #10 CLK = ~CLK;                   // 20 ns period
    end

    // ADC model whose popcount equals the table code of the muxed column
    always_comb begin
        int code;
        for (int a = 0; a < 4; a++) begin
            code = 0;
            for (int o = 0; o < 16; o++) begin
                if (sl_mux_sel[a*16+o]) code = int'(stim[adc_at + a*16 + o][3:0]);
            end
            adc_therm[a] = xbar_pkg::therm_t'((1 << code) - 1);
        end
    end

    task automatic check_program();
        int k, pkt;
        logic [15:0] w;
        logic b;
        xbar_pkg::line_sel_t bl, sl;
        k   = pcount - pc_start;
        pkt = st_pkt + k / (2*wc);
        w   = stim[data_at + st_base + k / (2*wc)][15:0];
        check_row_sel("wl_sel", wl_sel, 64'd1 << st_row);
        check_bias("bias", {wl_bias_sel, bl_bias_sel, sl_bias_sel}, 5'b11111);
        check_row_sel("sl_mux_sel", sl_mux_sel, '0);
        for (int c = 0; c < 64; c++) begin
            b  = w[c%16];
            bl = (c/16 == pkt) ? {1'b0, ~b, b} : 3'b100;
            sl = (c/16 == pkt) ? {1'b0, b, ~b} : 3'b100;
            if (k % 2) begin                      // Odd pulses swap BL and SL codes
                check_line_sel($sformatf("bl_sel[%0d]", c), bl_sel[c], sl);
                check_line_sel($sformatf("sl_sel[%0d]", c), sl_sel[c], bl);
            end else begin
                check_line_sel($sformatf("bl_sel[%0d]", c), bl_sel[c], bl);
                check_line_sel($sformatf("sl_sel[%0d]", c), sl_sel[c], sl);
            end
        end
        pcount++;
    endtask

    task automatic check_read();
        logic [63:0] mux;
        mux = '0;
        for (int a = 0; a < 4; a++) mux[a*16 + rcount%16] = 1'b1;
        check_row_sel("wl_sel", wl_sel, 64'd1 << rd_row);
        check_row_sel("sl_mux_sel", sl_mux_sel, mux);
        check_bias("bias", {wl_bias_sel, bl_bias_sel, sl_bias_sel}, 5'b0);
        for (int c = 0; c < 64; c++) begin
            check_line_sel($sformatf("bl_sel[%0d]", c), bl_sel[c], mux[c] ? 3'b001 : 3'b100);
            check_line_sel($sformatf("sl_sel[%0d]", c), sl_sel[c], mux[c] ? 3'b000 : 3'b100);
        end
        rcount++;
    endtask

    // FIFO models and output monitors that drive inputs 1 ns after the edge
    always @(posedge CLK) begin
        if (!RESET_ACC) begin
            if (!pop_n_instr) begin
                if (instr_empty) count_failure("instruction popped while empty");
                else begin
                    void'(instr_q.pop_front());
                    ipops++;
                end
            end
            if (!pop_n_data) begin
                if (data_empty) count_failure("data popped while empty");
                else begin
                    void'(data_q.pop_front());
                    dpops++;
                end
            end
            if (!push_n_out) begin
                if (out_full) count_failure("output pushed while full");
                else if (ocount >= 16) count_failure("more than 16 output words");
                else begin
                    check_word("out_din", out_din, stim[exp_at + ocount][15:0]);
                    ocount++;
                end
            end
            if (wl_bias_sel) check_program();
            if (sl_mux_sel != '0) check_read();
        end
        #1;
        instr_empty = (instr_q.size() == 0);
        instr_dout  = (instr_q.size() != 0) ? instr_q[0] : '0;
        data_empty  = (data_q.size() == 0);
        data_dout   = (data_q.size() != 0) ? data_q[0] : '0;
    end

    // Output FIFO full flag, random only while a read is under test
    initial begin
        void'($urandom(51565));
        out_full = 1'b0;
        forever begin
            @(posedge CLK);
            #1 out_full = rand_full && ($urandom % 3 == 0);
        end
    end

    function automatic int count_of(input int which);
        case (which)
            0: return pcount;
            1: return rcount;
            2: return ocount;
            default: return ipops;
        endcase
    endfunction

    task automatic wait_for_count(input int which, input int target, input string what);
        int t;
        t = 0;
        if (aborted) return;
        while (count_of(which) < target) begin
            @(posedge CLK);
            t++;
            if (t > 500) begin
                count_failure({"timeout waiting for ", what});
                aborted = 1;
                return;
            end
        end
    endtask

    task automatic expect_count(input int which, input int exp, input string what);
        if (!aborted && count_of(which) != exp)
            count_failure($sformatf("%s count is %0d, expected %0d", what, count_of(which), exp));
    endtask

    initial begin
        instr_empty = 1'b1;
        instr_dout  = '0;
        data_empty  = 1'b1;
        data_dout   = '0;
        $readmemh("bench/rram_stimulus.txt", stim);
        repeat (2) @(posedge CLK);
        #1 RESET_ACC = 1'b0;
        @(posedge CLK);
        if (!pop_n_instr || !pop_n_data || !push_n_out)
            count_failure("handshake active after reset");
        check_row_sel("wl_sel", wl_sel, '0);
        check_bias("bias", {wl_bias_sel, bl_bias_sel, sl_bias_sel}, 5'b0);
        for (int c = 0; c < 64; c++) begin
            check_line_sel($sformatf("bl_sel[%0d]", c), bl_sel[c], 3'b100);
            check_line_sel($sformatf("sl_sel[%0d]", c), sl_sel[c], 3'b100);
        end

        // One-packet store on row 5, packet 1
        st_row   = 5;
        st_pkt   = 1;
        st_base  = 0;
        pc_start = pcount;
        instr_q.push_back(stim[0]);
        data_q.push_back(stim[data_at][15:0]);
        wait_for_count(0, pc_start + 2*wc, "single store");
        repeat (4) @(posedge CLK);
        expect_count(0, pc_start + 2*wc, "program");

        // Burst of three packets with the data FIFO starved in between
        st_row   = 9;
        st_pkt   = 1;
        st_base  = 1;
        pc_start = pcount;
        instr_q.push_back(stim[1]);
        for (int p = 0; p < 3; p++) begin
            data_q.push_back(stim[data_at + 1 + p][15:0]);
            wait_for_count(0, pc_start + (p+1)*2*wc, "burst store packet");
            repeat (6) @(posedge CLK);
            expect_count(0, pc_start + (p+1)*2*wc, "program during stall");
            if (dpops != p + 2) count_failure("data pop count wrong during stall");
        end

        // Unknown code leaves no activity
        instr_q.push_back(stim[2]);
        wait_for_count(3, 3, "unknown instruction pop");
        repeat (5) @(posedge CLK);
        expect_count(0, 4 * 2*wc, "program");
        expect_count(1, 0, "read step");
        expect_count(2, 0, "output word");

        // Row read on row 3 under random full
        rd_row = 3;
        rand_full = 1;
        instr_q.push_back(stim[3]);
        wait_for_count(1, 16, "read scan");
        wait_for_count(2, 16, "output drain");
        repeat (5) @(posedge CLK);
        expect_count(1, 16, "read step");
        expect_count(2, 16, "output word");
        rand_full = 0;

        report_counts();
        if (value_errors == 0 && other_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
source/xbar_pkg.sv
source/ctrl_pkg.sv
source/instr_sequencer.sv
source/array_driver.sv
source/readout_buffer.sv
source/readout_packer.sv
source/rram_ctrl_top.sv
+incdir+include
bench/tb_rram_ctrl.sv

/* source/array_driver.sv */
`timescale 1ns/100ps
`default_nettype none

module array_driver (
    input  logic                    CLK,
    input  logic                    RESET_ACC,
    input  ctrl_pkg::xbar_cmd_t     cmd,
    output xbar_pkg::array_drive_t  drive
);

    localparam int num_col   = xbar_pkg::num_col;
    localparam int pkt_width = xbar_pkg::word_width;   // Columns per packet

    logic [num_col-1:0] weight_q;    // Weight bit per column
    logic [num_col-1:0] col_sel_q;   // Columns of the last loaded packet

    always_ff @(posedge CLK) begin
        if (RESET_ACC) begin
            col_sel_q <= '0;
        end else if (cmd.op == ctrl_pkg::cmd_load) begin
            for (int p = 0; p < num_col / pkt_width; p++) begin
                col_sel_q[p*pkt_width +: pkt_width] <= {pkt_width{p == cmd.packet}};
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (cmd.op == ctrl_pkg::cmd_load) begin
            weight_q[cmd.packet*pkt_width +: pkt_width] <= cmd.data;  // Bit j to column 16p+j
        end
    end

    always_comb begin
        xbar_pkg::line_sel_t bl_code;
        xbar_pkg::line_sel_t sl_code;
        int col;

        drive = '0;                          // No word line, read biases
        for (int c = 0; c < num_col; c++) begin
            drive.bl_sel[c] = 3'b100;        // Park on reference
            drive.sl_sel[c] = 3'b100;
        end

        case (cmd.op)
            ctrl_pkg::cmd_program: begin
                drive.wl_sel[cmd.row] = 1'b1;
                for (int c = 0; c < num_col; c++) begin
                    bl_code = {1'b0, ~weight_q[c], weight_q[c]};  // BL+ for a 1
                    sl_code = {1'b0, weight_q[c], ~weight_q[c]};
                    if (col_sel_q[c]) begin
                        drive.bl_sel[c] = cmd.col_pol ? sl_code : bl_code;  // Swap for BL-
                        drive.sl_sel[c] = cmd.col_pol ? bl_code : sl_code;
                    end
                end
                drive.wl_bias_sel = 1'b1;    // Write biases
                drive.bl_bias_sel = 3'b111;
                drive.sl_bias_sel = 1'b1;
            end
            ctrl_pkg::cmd_read_sel: begin
                drive.wl_sel[cmd.row] = 1'b1;
                for (int a = 0; a < xbar_pkg::num_adc; a++) begin
                    col = a * xbar_pkg::mux_ways + int'(cmd.col_offset);
                    drive.bl_sel[col]     = 3'b001;  // BL to read plus
                    drive.sl_sel[col]     = 3'b000;  // SL floats onto the ADC
                    drive.sl_mux_sel[col] = 1'b1;
                end
            end
            default: ;                       // Idle and load keep the array parked
        endcase
    end

    a_wl_onehot: assert property (@(posedge CLK) disable iff (RESET_ACC)
        $onehot0(drive.wl_sel));

endmodule

`default_nettype wire

/* source/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    parameter int instr_width  = 4;
    parameter int opcode_width = 16;

    // Instruction FIFO word with the code on top
    typedef struct packed {
        logic [instr_width-1:0]  code;
        logic [opcode_width-1:0] opcode;
    } instr_word_t;

    parameter logic [instr_width-1:0] instr_store_rram = 4'b0100;
    parameter logic [instr_width-1:0] instr_read_rram  = 4'b0101;

    // Low ten opcode bits shared by store and read
    typedef struct packed {
        xbar_pkg::packet_t burst;   // Packets minus one
        xbar_pkg::packet_t packet;  // First packet
        xbar_pkg::row_t    row;
    } store_op_t;

    typedef enum logic [1:0] {
        cmd_idle,
        cmd_load,      // Latch a weight packet
        cmd_program,   // One write pulse on the selected columns
        cmd_read_sel   // One mux step of the row scan
    } cmd_op_t;

    // Registered command from sequencer to the array side
    typedef struct packed {
        cmd_op_t                 op;
        xbar_pkg::row_t          row;
        logic                    col_pol;     // 0 drives BL+, 1 drives BL-
        xbar_pkg::col_offset_t   col_offset;
        xbar_pkg::packet_t       packet;
        xbar_pkg::data_word_t    data;        // Weights for cmd_load
    } xbar_cmd_t;

    typedef enum logic [1:0] {
        idle,
        store,
        read,
        drain
    } seq_state_t;

endpackage

`default_nettype wire

/* source/instr_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_sequencer #(
    parameter int write_cycles = 4   // Program pulses per polarity
) (
    input  logic                    CLK,
    input  logic                    RESET_ACC,
    input  logic                    instr_empty,
    input  ctrl_pkg::instr_word_t   instr_dout,
    output logic                    pop_n_instr,
    input  logic                    data_empty,
    input  xbar_pkg::data_word_t    data_dout,
    output logic                    pop_n_data,
    output ctrl_pkg::xbar_cmd_t     cmd,
    output logic                    drain_start,
    input  logic                    drain_done
);

    // Step counter covers both the pulse train and the 16-step scan
    localparam int step_width = $clog2(2 * write_cycles + xbar_pkg::mux_ways);
    localparam logic [step_width-1:0] last_pulse = step_width'(2 * write_cycles);
    localparam logic [step_width-1:0] last_scan  = step_width'(xbar_pkg::mux_ways - 1);

    ctrl_pkg::seq_state_t  state;
    ctrl_pkg::store_op_t   op_q;      // Row, first packet, burst
    logic [step_width-1:0] step;      // 0 is the load slot in store
    xbar_pkg::packet_t     pkt_cnt;   // Packets done in this burst
    logic                  take_instr;
    logic                  take_data;

    assign take_instr  = (state == ctrl_pkg::idle) && !instr_empty;
    assign take_data   = (state == ctrl_pkg::store) && (step == '0) && !data_empty;
    assign pop_n_instr = ~take_instr;
    assign pop_n_data  = ~take_data;

    always_ff @(posedge CLK) begin
        if (take_instr) begin
            op_q <= instr_dout.opcode[$bits(ctrl_pkg::store_op_t)-1:0];
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET_ACC) begin
            state       <= ctrl_pkg::idle;
            step        <= '0;
            pkt_cnt     <= '0;
            cmd         <= '0;       // cmd_idle
            drain_start <= 1'b0;
        end else begin
            cmd.op      <= ctrl_pkg::cmd_idle;  // Default between steps
            cmd.row     <= op_q.row;
            drain_start <= 1'b0;
            case (state)
                ctrl_pkg::idle: begin
                    if (take_instr) begin
                        step    <= '0;
                        pkt_cnt <= '0;
                        case (instr_dout.code)
                            ctrl_pkg::instr_store_rram: state <= ctrl_pkg::store;
                            ctrl_pkg::instr_read_rram:  state <= ctrl_pkg::read;
                            default:                    state <= ctrl_pkg::idle;  // Dropped
                        endcase
                    end
                end
                ctrl_pkg::store: begin
                    if (step == '0) begin
                        if (take_data) begin            // Stalls here on empty FIFO
                            cmd.op     <= ctrl_pkg::cmd_load;
                            cmd.packet <= op_q.packet + pkt_cnt;
                            cmd.data   <= data_dout;
                            step       <= step + 1'b1;
                        end
                    end else begin
                        cmd.op      <= ctrl_pkg::cmd_program;
                        cmd.col_pol <= ~step[0];        // Step 1 is polarity 0
                        if (step == last_pulse) begin
                            step    <= '0;
                            pkt_cnt <= pkt_cnt + 1'b1;
                            if (pkt_cnt == op_q.burst) begin
                                state <= ctrl_pkg::idle;
                            end
                        end else begin
                            step <= step + 1'b1;
                        end
                    end
                end
                ctrl_pkg::read: begin
                    cmd.op         <= ctrl_pkg::cmd_read_sel;
                    cmd.col_offset <= step[3:0];
                    if (step == last_scan) begin
                        step        <= '0;
                        drain_start <= 1'b1;            // Packer takes over
                        state       <= ctrl_pkg::drain;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                ctrl_pkg::drain: begin
                    if (drain_done) begin
                        state <= ctrl_pkg::idle;
                    end
                end
                default: state <= ctrl_pkg::idle;
            endcase
        end
    end

    // Data FIFO is only popped with a word present
    a_no_pop_empty: assert property (@(posedge CLK) disable iff (RESET_ACC)
        data_empty |-> pop_n_data);

    // Drain ends only on the packer's handshake
    a_drain_hold: assert property (@(posedge CLK) disable iff (RESET_ACC)
        (state == ctrl_pkg::drain && !drain_done) |=> state == ctrl_pkg::drain);

endmodule

`default_nettype wire

/* source/readout_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module readout_buffer (
    input  logic                    CLK,
    input  logic                    RESET_ACC,
    input  ctrl_pkg::xbar_cmd_t     cmd,
    input  xbar_pkg::therm_t        therm_codes [xbar_pkg::num_adc],
    input  logic [3:0]              rd_word_addr,
    output xbar_pkg::data_word_t    rd_word
);

    localparam int codes_per_word = xbar_pkg::word_width / xbar_pkg::adc_width;

    xbar_pkg::adc_code_t adc_bin [xbar_pkg::num_adc];   // Converted ADC outputs
    xbar_pkg::adc_code_t codes_q [xbar_pkg::num_col];   // One code per column

    // Thermometer to binary by a ones count that tolerates bubbles
    always_comb begin
        for (int a = 0; a < xbar_pkg::num_adc; a++) begin
            adc_bin[a] = '0;
            for (int b = 0; b < xbar_pkg::therm_width; b++) begin
                adc_bin[a] = adc_bin[a] + xbar_pkg::adc_code_t'(therm_codes[a][b]);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET_ACC) begin
            codes_q <= '{default: '0};
        end else if (cmd.op == ctrl_pkg::cmd_read_sel) begin
            for (int a = 0; a < xbar_pkg::num_adc; a++) begin
                codes_q[a*xbar_pkg::mux_ways + int'(cmd.col_offset)] <= adc_bin[a];
            end
        end
    end

    // Word w holds columns 4w..4w+3 with the lowest column in the low nibble
    always_comb begin
        for (int j = 0; j < codes_per_word; j++) begin
            rd_word[j*xbar_pkg::adc_width +: xbar_pkg::adc_width] =
                codes_q[int'(rd_word_addr) * codes_per_word + j];
        end
    end

endmodule

`default_nettype wire

/* source/readout_packer.sv */
`timescale 1ns/100ps
`default_nettype none

module readout_packer (
    input  logic                    CLK,
    input  logic                    RESET_ACC,
    input  logic                    drain_start,
    output logic                    drain_done,
    output logic [3:0]              rd_word_addr,
    input  xbar_pkg::data_word_t    rd_word,
    input  logic                    out_full,
    output logic                    push_n_out,
    output xbar_pkg::data_word_t    out_din
);

    logic       busy;       // Drain in progress
    logic [3:0] word_cnt;   // Next buffer word
    logic       accept;     // Output FIFO takes the word this cycle

    assign rd_word_addr = word_cnt;
    assign out_din      = rd_word;                // Buffer read is combinational
    assign accept       = busy && !out_full;      // Hold while full
    assign push_n_out   = ~accept;
    assign drain_done   = accept && (word_cnt == 4'd15);

    always_ff @(posedge CLK) begin
        if (RESET_ACC) begin
            busy     <= 1'b0;
            word_cnt <= '0;
        end else if (drain_start) begin
            busy     <= 1'b1;
            word_cnt <= '0;
        end else if (accept) begin
            word_cnt <= word_cnt + 1'b1;          // Wraps to 0 after the last word
            if (drain_done) begin
                busy <= 1'b0;
            end
        end
    end

    a_no_push_full: assert property (@(posedge CLK) disable iff (RESET_ACC)
        out_full |-> push_n_out);

endmodule

`default_nettype wire

/* source/rram_ctrl_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rram_ctrl_top #(
    parameter int write_cycles = 4
) (
    input  logic                                    CLK,
    input  logic                                    RESET_ACC,
    input  logic                                    instr_empty,    // Instruction FIFO
    input  ctrl_pkg::instr_word_t                   instr_dout,
    output logic                                    pop_n_instr,
    input  logic                                    data_empty,     // Input data FIFO
    input  xbar_pkg::data_word_t                    data_dout,
    output logic                                    pop_n_data,
    input  logic                                    out_full,       // Output FIFO
    output logic                                    push_n_out,
    output xbar_pkg::data_word_t                    out_din,
    input  xbar_pkg::therm_t                        adc_therm [xbar_pkg::num_adc],
    output logic [xbar_pkg::num_wl-1:0]             wl_sel,
    output xbar_pkg::line_sel_t [xbar_pkg::num_col-1:0] bl_sel,
    output xbar_pkg::line_sel_t [xbar_pkg::num_col-1:0] sl_sel,
    output logic [xbar_pkg::num_col-1:0]            sl_mux_sel,
    output logic                                    wl_bias_sel,
    output logic [2:0]                              bl_bias_sel,
    output logic                                    sl_bias_sel
);

    ctrl_pkg::xbar_cmd_t    cmd;
    xbar_pkg::array_drive_t drive;
    xbar_pkg::data_word_t   rd_word;
    logic [3:0]             rd_word_addr;
    logic                   drain_start;
    logic                   drain_done;

    instr_sequencer #(.write_cycles(write_cycles)) instr_sequencer_i (
        .CLK, .RESET_ACC,
        .instr_empty, .instr_dout, .pop_n_instr,
        .data_empty, .data_dout, .pop_n_data,
        .cmd, .drain_start, .drain_done
    );

    array_driver array_driver_i (.CLK, .RESET_ACC, .cmd, .drive);

    readout_buffer readout_buffer_i (
        .CLK, .RESET_ACC, .cmd,
        .therm_codes(adc_therm), .rd_word_addr, .rd_word
    );

    readout_packer readout_packer_i (
        .CLK, .RESET_ACC, .drain_start, .drain_done,
        .rd_word_addr, .rd_word, .out_full, .push_n_out, .out_din
    );

    // Macro pins
    assign wl_sel      = drive.wl_sel;
    assign bl_sel      = drive.bl_sel;
    assign sl_sel      = drive.sl_sel;
    assign sl_mux_sel  = drive.sl_mux_sel;
    assign wl_bias_sel = drive.wl_bias_sel;
    assign bl_bias_sel = drive.bl_bias_sel;
    assign sl_bias_sel = drive.sl_bias_sel;

endmodule

`default_nettype wire

/* source/xbar_pkg.sv */
`default_nettype none

package xbar_pkg;

    // Array geometry
    parameter int num_wl      = 64;   // Word lines
    parameter int num_col     = 64;   // Columns with one BL/SL pair each
    parameter int num_adc     = 4;    // Shared ADCs
    parameter int mux_ways    = 16;   // Columns behind each ADC mux
    parameter int therm_width = 15;   // Thermometer bits per ADC
    parameter int adc_width   = 4;    // Binary code bits
    parameter int word_width  = 16;   // FIFO data width

    typedef logic [5:0]             row_t;         // Word-line address
    typedef logic [3:0]             col_offset_t;  // Mux offset inside a group
    typedef logic [1:0]             packet_t;      // 16-column packet index
    typedef logic [adc_width-1:0]   adc_code_t;
    typedef logic [therm_width-1:0] therm_t;
    typedef logic [word_width-1:0]  data_word_t;

    // Per-column select with bit 0 plus, bit 1 minus and bit 2 reference
    typedef logic [2:0] line_sel_t;

    // Everything that goes to the macro pins
    typedef struct packed {
        logic [num_wl-1:0]          wl_sel;       // One-hot row select
        line_sel_t [num_col-1:0]    bl_sel;
        line_sel_t [num_col-1:0]    sl_sel;
        logic [num_col-1:0]         sl_mux_sel;   // Column to ADC mux
        logic                       wl_bias_sel;  // 1 is write bias
        logic [2:0]                 bl_bias_sel;  // Plus, minus, ref write bias
        logic                       sl_bias_sel;
    } array_drive_t;

endpackage

`default_nettype wire
